// ==== dv/asteroidFieldTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module asteroidFieldTb import asteroidPkg::*; ();

    localparam int CLOCK_PERIOD  = 8;
    localparam int RESET_CYCLES  = 10;
    localparam int FRAME_TIMEOUT = 20000;
    localparam int FRAME_CYCLES  = SCREEN_WIDTH * SCREEN_HEIGHT;  // one pixel per clock
    localparam int PLAYER_SIZE   = 8;
    localparam int ROW_COUNT     = 5;

    // one line of the stimulus table
    typedef struct packed {
        logic       active;     // player rectangle present in this row
        logic [7:0] rectX;      // player left edge
        logic [7:0] rectY;      // player top edge
        logic [7:0] frames;     // frame strobes to run
        logic       expectHit;  // hit flag at the end of the row
    } testRow;

    logic    clk;
    logic    resetN;
    logic    playerDraw;
    pixelPos scanPos;
    logic    startOfFrame;
    logic    asteroidDraw;
    pixelPos topLeft;
    logic    asteroidIsHit;

    testRow rows [ROW_COUNT];
    testRow curRow;

    // reference model state in 1/64 pixel
    int   modelX;
    int   modelY;
    int   speedX;
    int   speedY;
    logic modelHit;

    asteroidField i_asteroidField (
        .clk           (clk),
        .resetN        (resetN),
        .playerDraw    (playerDraw),
        .scanPos       (scanPos),
        .startOfFrame  (startOfFrame),
        .asteroidDraw  (asteroidDraw),
        .topLeft       (topLeft),
        .asteroidIsHit (asteroidIsHit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk = ~clk;
    end

    // true when a pixel lies in the square of the given side whose corner is (left,top)
    function automatic logic insideRect(input int x, input int y, input int left, input int top,
                                        input int size);
        return (x >= left) && (x < left + size) && (y >= top) && (y < top + size);
    endfunction

    // asteroid and player share at least one pixel that is on the screen
    function automatic logic rectsOverlap(input int left, input int top, input int rx,
                                          input int ry);
        int loX;
        int hiX;
        int loY;
        int hiY;
        loX = (left > rx) ? left : rx;
        loY = (top > ry) ? top : ry;
        hiX = (left + OBJECT_SIZE < rx + PLAYER_SIZE) ? left + OBJECT_SIZE - 1
                                                      : rx + PLAYER_SIZE - 1;
        hiY = (top + OBJECT_SIZE < ry + PLAYER_SIZE) ? top + OBJECT_SIZE - 1
                                                     : ry + PLAYER_SIZE - 1;
        if (loX < 0) loX = 0;  // clip to the visible screen
        if (loY < 0) loY = 0;
        if (hiX > SCREEN_WIDTH - 1) hiX = SCREEN_WIDTH - 1;
        if (hiY > SCREEN_HEIGHT - 1) hiY = SCREEN_HEIGHT - 1;
        return (loX <= hiX) && (loY <= hiY);
    endfunction

    // the far edge band of the square covers the border line
    function automatic logic farBandOnBorder(input int low, input int border);
        return (border - low >= OBJECT_SIZE - EDGE_BAND) && (border - low < OBJECT_SIZE);
    endfunction

    task automatic checkValue(input string name, input logic signed [31:0] expected,
                              input logic signed [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic applyReset();
        resetN = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        resetN = 1'b1;  // released on a falling edge like every other input
    endtask

    // counts falling edges until the strobe is seen
    // returns at once when the strobe is already high
    task automatic waitForFrame(output int cycles);
        cycles = 0;
        while (!startOfFrame) begin
            if (cycles >= FRAME_TIMEOUT) begin
                $display("Timeout: no startOfFrame within %0d cycles", FRAME_TIMEOUT);
                $display("Simulation finished: FAIL");
                $fatal(1, "frame strobe missing");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // compares asteroidDraw with square membership and the scan position with the raster order
    // on every pixel up to the next strobe, starting at the pixel after the origin
    task automatic checkDrawFrame();
        int cycles;
        int left;
        int top;
        left   = modelX >>> FIXED_POINT_SHIFT;
        top    = modelY >>> FIXED_POINT_SHIFT;
        cycles = 0;
        while (!startOfFrame) begin
            if (cycles >= FRAME_TIMEOUT) begin
                $display("Timeout: frame did not end within %0d cycles", FRAME_TIMEOUT);
                $display("Simulation finished: FAIL");
                $fatal(1, "frame end missing");
            end else begin
                checkValue("scanPos.x", (cycles + 1) % SCREEN_WIDTH, scanPos.x);
                checkValue("scanPos.y", (cycles + 1) / SCREEN_WIDTH, scanPos.y);
                checkValue("asteroidDraw", insideRect(scanPos.x, scanPos.y, left, top,
                           OBJECT_SIZE), asteroidDraw);
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // what happens during one frame scan at the current model position
    task automatic modelFrameScan();
        int left;
        int top;
        left = modelX >>> FIXED_POINT_SHIFT;
        top  = modelY >>> FIXED_POINT_SHIFT;
        if (curRow.active && rectsOverlap(left, top, curRow.rectX, curRow.rectY)) begin
            modelHit = 1'b1;  // frozen for the rest of the row
            speedX   = 0;
            speedY   = 0;
        end
        // the square also has to be on the screen along the other axis
        if (speedX > 0 && farBandOnBorder(left, SCREEN_WIDTH - 1) &&
            top < SCREEN_HEIGHT && top + OBJECT_SIZE > 0) begin
            modelX = INITIAL_X << FIXED_POINT_SHIFT;
        end
        if (speedY > 0 && farBandOnBorder(top, SCREEN_HEIGHT - 1) &&
            left < SCREEN_WIDTH && left + OBJECT_SIZE > 0) begin
            modelY = INITIAL_Y << FIXED_POINT_SHIFT;
        end
    endtask

    // player rectangle of the current row, redrawn on every falling edge
    always @(negedge clk) begin
        playerDraw <= curRow.active &&
                      insideRect(scanPos.x, scanPos.y, curRow.rectX, curRow.rectY, PLAYER_SIZE);
    end

    initial begin
        int cycles;
        resetN     = 1'b0;
        playerDraw = 1'b0;
        curRow     = '0;
        rows[0] = '{1'b0, 8'd0, 8'd0, 8'd40, 1'b0};      // free flight past the first x reload
        rows[1] = '{1'b0, 8'd0, 8'd0, 8'd90, 1'b0};      // long flight with x and y reloads
        rows[2] = '{1'b1, 8'd100, 8'd70, 8'd30, 1'b1};   // player on the path
        rows[3] = '{1'b1, 8'd52, 8'd52, 8'd10, 1'b1};    // player on the start point
        rows[4] = '{1'b1, 8'd10, 8'd100, 8'd40, 1'b0};   // player far from the path

        for (int r = 0; r < ROW_COUNT; r++) begin
            curRow = rows[r];
            applyReset();
            checkValue("asteroidIsHit", 0, asteroidIsHit);
            checkValue("topLeft.x", INITIAL_X, topLeft.x);
            checkValue("topLeft.y", INITIAL_Y, topLeft.y);
            checkValue("scanPos.x", 0, scanPos.x);
            checkValue("scanPos.y", 0, scanPos.y);
            checkValue("startOfFrame", 0, startOfFrame);
            modelX   = INITIAL_X << FIXED_POINT_SHIFT;
            modelY   = INITIAL_Y << FIXED_POINT_SHIFT;
            speedX   = X_SPEED;
            speedY   = Y_SPEED;
            modelHit = 1'b0;
            modelFrameScan();  // the scan before the first strobe
            for (int f = 1; f <= curRow.frames; f++) begin
                waitForFrame(cycles);
                if (f == 1) checkValue("startOfFrame delay", FRAME_CYCLES, cycles);
                checkValue("scanPos.x", 0, scanPos.x);  // the strobe marks the origin
                checkValue("scanPos.y", 0, scanPos.y);
                @(negedge clk);  // new position shows one cycle after the strobe
                checkValue("startOfFrame", 0, startOfFrame);
                checkValue("asteroidIsHit", modelHit, asteroidIsHit);
                modelX += speedX;
                modelY += speedY;
                checkValue("topLeft.x", modelX >>> FIXED_POINT_SHIFT, topLeft.x);
                checkValue("topLeft.y", modelY >>> FIXED_POINT_SHIFT, topLeft.y);
                if (f == 1) checkDrawFrame();
                modelFrameScan();
            end
            checkValue("asteroidIsHit", curRow.expectHit, asteroidIsHit);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/asteroidPkg.sv
verilog/frameScanner.sv
verilog/objectRenderer.sv
verilog/collisionDetector.sv
verilog/asteroidMove.sv
verilog/asteroidField.sv
dv/asteroidFieldTb.sv

// ==== verilog/asteroidField.sv ====
`timescale 1ns/1ps
`default_nettype none

module asteroidField import asteroidPkg::*; (
    input  logic    clk,
    input  logic    resetN,
    input  logic    playerDraw,     // player sprite covers the current pixel
    output pixelPos scanPos,        // pixel being scanned
    output logic    startOfFrame,   // one cycle per frame at the origin
    output logic    asteroidDraw,   // asteroid covers the current pixel
    output pixelPos topLeft,        // asteroid corner in whole pixels
    output logic    asteroidIsHit   // asteroid has touched the player
);

    edgeCode       objEdge;    // edge regions under the scan, renderer to detector
    collisionEvent collision;  // registered strobes, detector to mover

    // walks the screen one pixel per clock
    frameScanner i_frameScanner (
        .clk          (clk),
        .resetN       (resetN),
        .scanPos      (scanPos),
        .startOfFrame (startOfFrame)
    );

    // combinational, so its outputs belong to the same pixel as scanPos
    objectRenderer i_objectRenderer (
        .scanPos      (scanPos),
        .topLeft      (topLeft),
        .asteroidDraw (asteroidDraw),
        .objEdge      (objEdge)
    );

    // adds the first cycle of the player-to-hit latency
    collisionDetector i_collisionDetector (
        .clk          (clk),
        .resetN       (resetN),
        .scanPos      (scanPos),
        .asteroidDraw (asteroidDraw),
        .objEdge      (objEdge),
        .playerDraw   (playerDraw),
        .collision    (collision)
    );

    // adds the second cycle, so asteroidIsHit rises two cycles after the overlap pixel
    asteroidMove i_asteroidMove (
        .clk           (clk),
        .resetN        (resetN),
        .startOfFrame  (startOfFrame),
        .collision     (collision),
        .asteroidIsHit (asteroidIsHit),
        .topLeft       (topLeft)
    );

endmodule

`default_nettype wire

// ==== verilog/asteroidMove.sv ====
`timescale 1ns/1ps
`default_nettype none

module asteroidMove import asteroidPkg::*; (
    input  logic          clk,
    input  logic          resetN,
    input  logic          startOfFrame,   // position advances on this strobe
    input  collisionEvent collision,      // registered report from the detector
    output logic          asteroidIsHit,  // sticky until reset once the player is touched
    output pixelPos       topLeft         // whole-pixel corner for the renderer
);

    // corner position in 1/64 pixel
    logic signed [FIXED_WIDTH-1:0] posX;
    logic signed [FIXED_WIDTH-1:0] posY;

    // velocity in 1/64 pixel per frame, zeroed for good after a hit
    logic signed [FIXED_WIDTH-1:0] xSpeed;
    logic signed [FIXED_WIDTH-1:0] ySpeed;

    logic reloadX;  // x runs into a side border it is moving toward
    logic reloadY;  // y runs into the top or bottom border it is moving toward

    // a border touch only counts when the axis is heading into that border
    // so the asteroid is not pulled back while it moves away from it
    assign reloadX = collision.borderCollision &&
                     ((collision.hitEdge.left && xSpeed < 0) ||
                      (collision.hitEdge.right && xSpeed > 0));
    assign reloadY = collision.borderCollision &&
                     ((collision.hitEdge.top && ySpeed < 0) ||
                      (collision.hitEdge.bottom && ySpeed > 0));

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            posX          <= FIXED_WIDTH'(INITIAL_X_FIXED);
            posY          <= FIXED_WIDTH'(INITIAL_Y_FIXED);
            xSpeed        <= FIXED_WIDTH'(X_SPEED);
            ySpeed        <= FIXED_WIDTH'(Y_SPEED);
            asteroidIsHit <= 1'b0;
        end else begin
            // touching the player stops the asteroid where it is
            if (collision.playerCollision) begin
                asteroidIsHit <= 1'b1;
                xSpeed        <= '0;
                ySpeed        <= '0;
            end

            if (reloadX) begin
                posX <= FIXED_WIDTH'(INITIAL_X_FIXED);  // fraction is cleared as well
            end
            if (reloadY) begin
                posY <= FIXED_WIDTH'(INITIAL_Y_FIXED);
            end

            // the frame step is written last so it wins over a reload in the same cycle
            if (startOfFrame) begin
                posX <= posX + xSpeed;
                posY <= posY + ySpeed;
            end
        end
    end

    // arithmetic shift keeps the sign for a corner left of or above the screen
    always_comb begin
        topLeft.x = PIXEL_WIDTH'(posX >>> FIXED_POINT_SHIFT);
        topLeft.y = PIXEL_WIDTH'(posY >>> FIXED_POINT_SHIFT);
    end

    // after a hit the flag stays up and the asteroid does not move again
    frozenAfterHit: assert property (@(posedge clk) disable iff (!resetN)
        asteroidIsHit |=> (asteroidIsHit && xSpeed == 0 && ySpeed == 0 &&
                           $stable(posX) && $stable(posY)));

endmodule

`default_nettype wire

// ==== verilog/asteroidPkg.sv ====
`default_nettype none

package asteroidPkg;

    // the visible screen, counted in whole pixels
    localparam int SCREEN_WIDTH  = 160;  // columns per line
    localparam int SCREEN_HEIGHT = 120;  // lines per frame
    localparam int COORD_WIDTH   = 8;    // wide enough for any on-screen column or row

    // screen coordinates are signed so an object can sit partly off the screen
    localparam int PIXEL_WIDTH = 11;

    // the asteroid is a plain square with an edge band on every side
    localparam int OBJECT_SIZE = 16;  // side length in pixels
    localparam int EDGE_BAND   = 4;   // how far an edge region reaches into the square

    // positions and speeds are kept in 1/64 pixel so slow diagonal motion stays smooth
    localparam int FIXED_POINT_SHIFT = 6;
    localparam int FIXED_WIDTH       = 32;  // signed fixed-point position width

    localparam int INITIAL_X = 50;  // left edge after reset, in pixels
    localparam int INITIAL_Y = 50;  // top edge after reset, in pixels

    // the same start point in fixed point, also used for the border reload
    localparam int INITIAL_X_FIXED = INITIAL_X << FIXED_POINT_SHIFT;
    localparam int INITIAL_Y_FIXED = INITIAL_Y << FIXED_POINT_SHIFT;

    localparam int X_SPEED = 160;  // 2.5 pixels per frame to the right
    localparam int Y_SPEED = 48;   // 0.75 pixel per frame downward

    // one point on the screen, x is the column and y the row
    typedef struct packed {
        logic signed [PIXEL_WIDTH-1:0] x;
        logic signed [PIXEL_WIDTH-1:0] y;
    } pixelPos;

    // which edge regions of the square cover the current pixel
    // corners set two flags at once
    typedef struct packed {
        logic left;
        logic top;
        logic right;
        logic bottom;
    } edgeCode;

    // registered collision report handed from the detector to the mover
    typedef struct packed {
        logic    borderCollision;  // asteroid pixel drawn on the outermost ring of the screen
        logic    playerCollision;  // asteroid and player drawn on the same pixel
        edgeCode hitEdge;          // edge flags that face the border being touched
    } collisionEvent;

endpackage

`default_nettype wire

// ==== verilog/collisionDetector.sv ====
`timescale 1ns/1ps
`default_nettype none

module collisionDetector import asteroidPkg::*; (
    input  logic          clk,
    input  logic          resetN,
    input  pixelPos       scanPos,       // pixel under the scan
    input  logic          asteroidDraw,  // asteroid covers this pixel
    input  edgeCode       objEdge,       // edge regions of the asteroid at this pixel
    input  logic          playerDraw,    // player covers this pixel
    output collisionEvent collision      // one-cycle strobes, one cycle after the pixel
);

    logic          onLeftCol;
    logic          onRightCol;
    logic          onTopRow;
    logic          onBottomRow;
    collisionEvent nextEvent;  // what the current pixel reports

    // the outermost ring of visible pixels counts as the border
    always_comb begin
        onLeftCol   = (scanPos.x == 0);
        onRightCol  = (scanPos.x == SCREEN_WIDTH - 1);
        onTopRow    = (scanPos.y == 0);
        onBottomRow = (scanPos.y == SCREEN_HEIGHT - 1);
    end

    always_comb begin
        nextEvent.borderCollision = asteroidDraw &&
                                    (onLeftCol || onRightCol || onTopRow || onBottomRow);
        nextEvent.playerCollision = asteroidDraw && playerDraw;

        // keep only the edge flags that face the border under the scan
        nextEvent.hitEdge.left   = objEdge.left && onLeftCol;
        nextEvent.hitEdge.top    = objEdge.top && onTopRow;
        nextEvent.hitEdge.right  = objEdge.right && onRightCol;
        nextEvent.hitEdge.bottom = objEdge.bottom && onBottomRow;
    end

    // every pixel gets a fresh report, so a strobe lasts exactly one cycle
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            collision <= '0;
        end else begin
            collision <= nextEvent;
        end
    end

    // a strobe or an edge flag always traces back to an asteroid pixel on the previous cycle
    // the edge flags come from the renderer, which must only raise them inside the square
    strobeNeedsAsteroid: assert property (@(posedge clk) disable iff (!resetN)
        (collision.borderCollision || collision.playerCollision || (|collision.hitEdge))
            |-> $past(asteroidDraw));

endmodule

`default_nettype wire

// ==== verilog/frameScanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameScanner import asteroidPkg::*; (
    input  logic    clk,
    input  logic    resetN,
    output pixelPos scanPos,      // pixel being scanned in this cycle
    output logic    startOfFrame  // high for the single cycle spent at the origin
);

    logic [COORD_WIDTH-1:0] colCount;  // 0 to 159
    logic [COORD_WIDTH-1:0] rowCount;  // 0 to 119
    logic                   lastCol;
    logic                   lastRow;

    assign lastCol = (colCount == COORD_WIDTH'(SCREEN_WIDTH - 1));
    assign lastRow = (rowCount == COORD_WIDTH'(SCREEN_HEIGHT - 1));

    // column counter carries into the row counter, both wrap at the screen size
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            colCount <= '0;
            rowCount <= '0;
        end else begin
            if (lastCol) begin
                colCount <= '0;
                if (lastRow) begin
                    rowCount <= '0;  // frame done, back to the top line
                end else begin
                    rowCount <= rowCount + 1'b1;
                end
            end else begin
                colCount <= colCount + 1'b1;
            end
        end
    end

    // the strobe is registered from the last pixel so it lines up with the wrap to (0,0)
    // and the reset state at the origin does not fire it
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            startOfFrame <= 1'b0;
        end else begin
            startOfFrame <= lastCol && lastRow;
        end
    end

    assign scanPos = '{x: PIXEL_WIDTH'(colCount), y: PIXEL_WIDTH'(rowCount)};  // zero extended

    // the strobe register and the counters must agree on where a frame begins
    originStrobe: assert property (@(posedge clk) disable iff (!resetN)
        startOfFrame |-> (colCount == '0 && rowCount == '0));

endmodule

`default_nettype wire

// ==== verilog/objectRenderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module objectRenderer import asteroidPkg::*; (
    input  pixelPos scanPos,       // pixel under the scan
    input  pixelPos topLeft,       // asteroid corner, may be negative when partly off screen
    output logic    asteroidDraw,  // pixel lies inside the square
    output edgeCode objEdge        // edge regions covering the pixel, zero outside the square
);

    // offsets of the scan inside the square, one bit wider so the subtraction cannot wrap
    logic signed [PIXEL_WIDTH:0] offsetX;
    logic signed [PIXEL_WIDTH:0] offsetY;

    logic insideX;  // column offset within 0 to 15
    logic insideY;  // row offset within 0 to 15
    logic nearX;    // left band
    logic farX;     // right band
    logic nearY;    // top band
    logic farY;     // bottom band

    // true when an offset falls on the square along one axis
    function automatic logic inSpan(input logic signed [PIXEL_WIDTH:0] offset);
        return (offset >= 0) && (offset < OBJECT_SIZE);
    endfunction

    // both operands are sign extended to the offset width before subtracting
    always_comb begin
        offsetX = $signed(scanPos.x) - $signed(topLeft.x);
        offsetY = $signed(scanPos.y) - $signed(topLeft.y);
    end

    always_comb begin
        insideX = inSpan(offsetX);
        insideY = inSpan(offsetY);

        // a band test only matters once the offset is known to be on the square
        nearX = (offsetX < EDGE_BAND);
        farX  = (offsetX >= OBJECT_SIZE - EDGE_BAND);  // offsets 12 to 15
        nearY = (offsetY < EDGE_BAND);
        farY  = (offsetY >= OBJECT_SIZE - EDGE_BAND);
    end

    assign asteroidDraw = insideX && insideY;

    // the middle of the square leaves every flag low
    always_comb begin
        objEdge.left   = asteroidDraw && nearX;
        objEdge.top    = asteroidDraw && nearY;
        objEdge.right  = asteroidDraw && farX;
        objEdge.bottom = asteroidDraw && farY;
    end

endmodule

`default_nettype wire
